//--- ks10_defines.svh
// Bus fields use the KS-10 numbering 0 to 35 left to right, and all addresses are 18-bit octal
`ifndef KS10_DEFINES_SVH
`define KS10_DEFINES_SVH

//////////////////////////////
// Flag bits in the address word
//////////////////////////////

// Read cycle
`define KS_READ_BIT 3
// Write cycle
`define KS_WRITE_BIT 5
// Physical reference, no paging
`define KS_PHYS_BIT 8
// IO space instead of memory
`define KS_IO_BIT 10

//////////////////////////////
// Console addresses
//////////////////////////////

// Start vector read by microcode at power-up
`define CON_VECTOR_ADDR 18'o200000
// Console copy of the status block, one word per index
`define CON_STAT_BASE 18'o200100
// First saved register of the halt status block in memory
`define HSB_REG_BASE 18'o376000

// JRST to the bootloader entry point
`define CON_START_WORD 36'o254000030600
// Cause, PC and 18 saved registers
`define HSB_COUNT 20

`endif

//--- ks10Pkg.sv
// Types only; widths follow the KS-10 bit order with bit 0 as the most significant bit
package ks10Pkg;

   //////////////////////////////
   // Bus words
   //////////////////////////////

   // Full 36-bit bus word, data or address with flags
   typedef logic [0:35] busWordT;

   // Address field of the address word
   typedef logic [18:35] busAddrT;

   // Index into the status copy
   // 0 is the cause, 1 is the PC, 2 to 19 hold o376000 to o376021
   typedef logic [4:0] statIdxT;

   //////////////////////////////
   // Halt causes
   //////////////////////////////

   // Decoded from bits 24 to 35 of the cause word
   typedef enum logic [3:0] {
      haltStartup,
      haltInstruction,
      haltConsole,
      haltIoPageFail,
      haltIllegalIntr,
      haltZeroVector,
      haltIllegalDispatch,
      haltStartCheck,
      haltUnknown
   } haltCauseT;

   //////////////////////////////
   // Pipeline cycle kinds
   //////////////////////////////

   // Only the two read kinds get an acknowledge
   typedef enum logic [1:0] {
      accNone,
      accVecRead,
      accStatRead,
      accStatWrite
   } accessT;

endpackage

//--- busDecode.sv
// Samples the bus only when clken is high; a request outside the console map is dropped silently
`include "ks10_defines.svh"

module busDecode (
   input  logic             clk,
   input  logic             rstN,
   input  logic             clken,
   input  logic             busREQI,
   input  ks10Pkg::busWordT busADDRI,
   input  ks10Pkg::busWordT busDATAI,
   output ks10Pkg::accessT  access,
   output ks10Pkg::statIdxT statIdx,
   output ks10Pkg::busWordT wrData
);

   // Flags split out of the address word
   logic             isRead;
   logic             isWrite;
   logic             isPhys;
   logic             isIo;
   ks10Pkg::busAddrT addr;

   // Offsets from the two mapped windows
   ks10Pkg::busAddrT statOff;
   ks10Pkg::busAddrT hsbOff;

   // Decode result before the stage register
   ks10Pkg::accessT  nextAccess;
   ks10Pkg::statIdxT nextIdx;

   assign isRead  = busADDRI[`KS_READ_BIT];
   assign isWrite = busADDRI[`KS_WRITE_BIT];
   assign isPhys  = busADDRI[`KS_PHYS_BIT];
   assign isIo    = busADDRI[`KS_IO_BIT];
   assign addr    = busADDRI[18:35];

   // Wraps for addresses below the base, which then fail the range test
   assign statOff = addr - `CON_STAT_BASE;
   assign hsbOff  = addr - `HSB_REG_BASE;

   //////////////////////////////
   // Cycle classification
   //////////////////////////////

   always_comb
   begin
      nextAccess = ks10Pkg::accNone;
      nextIdx    = '0;
      if (busREQI && isPhys)
      begin
         if (isIo && isRead)
         begin
            // Console reads live in IO space
            if (addr == `CON_VECTOR_ADDR)
            begin
               nextAccess = ks10Pkg::accVecRead;
            end
            else if (statOff < `HSB_COUNT)
            begin
               nextAccess = ks10Pkg::accStatRead;
               nextIdx    = statOff[31:35];
            end
         end
         else if (!isIo && isWrite)
         begin
            // Halt status block writes go to memory, we only snoop
            if (addr == 18'o000000)
            begin
               nextAccess = ks10Pkg::accStatWrite;
               nextIdx    = 5'd0;
            end
            else if (addr == 18'o000001)
            begin
               nextAccess = ks10Pkg::accStatWrite;
               nextIdx    = 5'd1;
            end
            else if (hsbOff < `HSB_COUNT - 2)
            begin
               // Saved registers start after cause and PC
               nextAccess = ks10Pkg::accStatWrite;
               nextIdx    = hsbOff[31:35] + 5'd2;
            end
         end
      end
   end

   //////////////////////////////
   // Stage 1 registers
   //////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         access <= ks10Pkg::accNone;
      else if (clken)
         access <= nextAccess;
   end

   // Payload, only meaningful when access is not none
   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         statIdx <= nextIdx;
         wrData  <= busDATAI;
      end
   end

   // A bus cycle is either a read or a write, never both
   assert property (@(posedge clk) disable iff (!rstN)
      (clken && busREQI) |-> !(isRead && isWrite));

endmodule

//--- statusCapture.sv
// Holds the last value written to each status word; cause codes outside the KS-10 list map to unknown
`include "ks10_defines.svh"

module statusCapture (
   input  logic                clk,
   input  logic                rstN,
   input  logic                clken,
   input  ks10Pkg::accessT     access,
   input  ks10Pkg::statIdxT    statIdx,
   input  ks10Pkg::busWordT    wrData,
   output ks10Pkg::accessT     rdAccess,
   output ks10Pkg::busWordT    rdData,
   output ks10Pkg::haltCauseT  haltCause,
   output logic                haltValid
);

   // Captured words, indexed as statIdxT
   ks10Pkg::busWordT   hsbRegs [`HSB_COUNT];

   // Write strobes for this stage
   logic               statWrite;
   logic               causeWrite;
   ks10Pkg::haltCauseT nextCause;

   assign statWrite  = (access == ks10Pkg::accStatWrite);
   assign causeWrite = statWrite && (statIdx == 5'd0);

   //////////////////////////////
   // Halt cause decode
   //////////////////////////////

   // Cause code sits in the right half, bits 24 to 35
   always_comb
   begin
      case (wrData[24:35])
         12'o0000: nextCause = ks10Pkg::haltStartup;
         12'o0001: nextCause = ks10Pkg::haltInstruction;
         12'o0002: nextCause = ks10Pkg::haltConsole;
         12'o0100: nextCause = ks10Pkg::haltIoPageFail;
         12'o0101: nextCause = ks10Pkg::haltIllegalIntr;
         12'o0102: nextCause = ks10Pkg::haltZeroVector;
         12'o1000: nextCause = ks10Pkg::haltIllegalDispatch;
         12'o1005: nextCause = ks10Pkg::haltStartCheck;
         default:  nextCause = ks10Pkg::haltUnknown;
      endcase
   end

   //////////////////////////////
   // Status register file
   //////////////////////////////

   // Writes land here one stage before a following read looks
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         for (int i = 0; i < `HSB_COUNT; i++)
            hsbRegs[i] <= '0;
      end
      else if (clken && statWrite)
      begin
         hsbRegs[statIdx] <= wrData;
      end
   end

   // Cause follows the index-0 write, valid pulses for one clken cycle
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         haltCause <= ks10Pkg::haltStartup;
         haltValid <= 1'b0;
      end
      else if (clken)
      begin
         haltValid <= causeWrite;
         if (causeWrite)
            haltCause <= nextCause;
      end
   end

   //////////////////////////////
   // Read selection
   //////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         rdAccess <= ks10Pkg::accNone;
      else if (clken)
         rdAccess <= access;
   end

   // Data is ignored downstream unless rdAccess is a read
   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         if (access == ks10Pkg::accVecRead)
            rdData <= `CON_START_WORD;
         else
            rdData <= hsbRegs[statIdx];
      end
   end

   // Stage 1 must never hand over an index past the register file
   assert property (@(posedge clk) disable iff (!rstN)
      (access inside {ks10Pkg::accStatRead, ks10Pkg::accStatWrite})
         |-> (statIdx < `HSB_COUNT));

endmodule

//--- conResponse.sv
// Drives the bus response for one clken cycle per read; writes and unmapped cycles stay silent
module conResponse (
   input  logic             clk,
   input  logic             rstN,
   input  logic             clken,
   input  ks10Pkg::accessT  rdAccess,
   input  ks10Pkg::busWordT rdData,
   output logic             busACKO,
   output ks10Pkg::busWordT busDATAO
);

   // Only console reads are answered
   logic isRead;

   assign isRead = (rdAccess == ks10Pkg::accVecRead) ||
                   (rdAccess == ks10Pkg::accStatRead);

   //////////////////////////////
   // Stage 3 registers
   //////////////////////////////

   // Acknowledge for one clken cycle
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         busACKO <= 1'b0;
      else if (clken)
         busACKO <= isRead;
   end

   // Data bus idles at zero so it can be ORed onto a shared bus
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         busDATAO <= '0;
      end
      else if (clken)
      begin
         if (isRead)
            busDATAO <= rdData;
         else
            busDATAO <= '0;
      end
   end

   // Read data handed over by stage 2 is always a known word
   assert property (@(posedge clk) disable iff (!rstN)
      (clken && isRead) |-> !$isunknown(rdData));

endmodule

//--- conTop.sv
// Console target only; it never requests the bus and answers reads two clken cycles after sampling
module conTop (
   input  logic                clk,
   input  logic                rstN,
   input  logic                clken,
   input  logic                busREQI,
   input  ks10Pkg::busWordT    busADDRI,
   input  ks10Pkg::busWordT    busDATAI,
   output logic                busACKO,
   output ks10Pkg::busWordT    busDATAO,
   output ks10Pkg::haltCauseT  haltCause,
   output logic                haltValid
);

   // Stage 1 to stage 2
   ks10Pkg::accessT  access;
   ks10Pkg::statIdxT statIdx;
   ks10Pkg::busWordT wrData;

   // Stage 2 to stage 3
   ks10Pkg::accessT  rdAccess;
   ks10Pkg::busWordT rdData;

   // Bus sample and address decode
   busDecode uDecode (
      .clk      (clk),
      .rstN     (rstN),
      .clken    (clken),
      .busREQI  (busREQI),
      .busADDRI (busADDRI),
      .busDATAI (busDATAI),
      .access   (access),
      .statIdx  (statIdx),
      .wrData   (wrData)
   );

   // Halt status copy and read mux
   statusCapture uCapture (
      .clk       (clk),
      .rstN      (rstN),
      .clken     (clken),
      .access    (access),
      .statIdx   (statIdx),
      .wrData    (wrData),
      .rdAccess  (rdAccess),
      .rdData    (rdData),
      .haltCause (haltCause),
      .haltValid (haltValid)
   );

   // Acknowledge and read data
   conResponse uResponse (
      .clk      (clk),
      .rstN     (rstN),
      .clken    (clken),
      .rdAccess (rdAccess),
      .rdData   (rdData),
      .busACKO  (busACKO),
      .busDATAO (busDATAO)
   );

endmodule

//--- tbCon.sv
// Self-checking testbench for conTop; clken is random, reads are answered in order, stops at first error
`include "ks10_defines.svh"

module tbCon;

   // Random transactions in the last test plus an allowance for the directed ones
   localparam int numRandom = 400;
   localparam int numTrans = numRandom + 100;
   // Sixteen cycles per transaction against about 1.3 on average
   localparam int watchdogTime = (numTrans * 16 + 200) * 40;

   logic               clk;
   logic               rstN;
   logic               clken;
   logic               busREQI;
   ks10Pkg::busWordT   busADDRI;
   ks10Pkg::busWordT   busDATAI;
   logic               busACKO;
   ks10Pkg::busWordT   busDATAO;
   ks10Pkg::haltCauseT haltCause;
   logic               haltValid;

   // Reference state
   logic [31:0]        seed = 32'h12ff4be7;
   ks10Pkg::busWordT   shadow [`HSB_COUNT];
   ks10Pkg::busWordT   ackQ [$];
   ks10Pkg::haltCauseT causeQ [$];
   string              testName = "reset";
   logic [11:0]        causeCodes [9] = '{12'o0000, 12'o0001, 12'o0002, 12'o0100,
                                          12'o0101, 12'o0102, 12'o1000, 12'o1005, 12'o0777};

   conTop UUT (
      .clk       (clk),
      .rstN      (rstN),
      .clken     (clken),
      .busREQI   (busREQI),
      .busADDRI  (busADDRI),
      .busDATAI  (busDATAI),
      .busACKO   (busACKO),
      .busDATAO  (busDATAO),
      .haltCause (haltCause),
      .haltValid (haltValid)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // LCG step with the Numerical Recipes constants
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // clken high about three times in four
   function automatic logic randEnable();
      return nextRand() > 32'h4000_0000;
   endfunction

   function automatic ks10Pkg::busWordT randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = nextRand();
      lo = nextRand();
      return {hi[3:0], lo};
   endfunction

   // Address word with the flag bits in KS-10 order
   function automatic ks10Pkg::busWordT makeAddr(logic rd, logic wr, logic phys, logic io,
                                                 logic [17:0] ad);
      ks10Pkg::busWordT w;
      w = '0;
      w[`KS_READ_BIT]  = rd;
      w[`KS_WRITE_BIT] = wr;
      w[`KS_PHYS_BIT]  = phys;
      w[`KS_IO_BIT]    = io;
      w[18:35]         = ad;
      return w;
   endfunction

   // Halt cause list of the KS-10 microcode
   function automatic ks10Pkg::haltCauseT causeOf(logic [11:0] code);
      case (code)
         12'o0000: return ks10Pkg::haltStartup;
         12'o0001: return ks10Pkg::haltInstruction;
         12'o0002: return ks10Pkg::haltConsole;
         12'o0100: return ks10Pkg::haltIoPageFail;
         12'o0101: return ks10Pkg::haltIllegalIntr;
         12'o0102: return ks10Pkg::haltZeroVector;
         12'o1000: return ks10Pkg::haltIllegalDispatch;
         12'o1005: return ks10Pkg::haltStartCheck;
         default:  return ks10Pkg::haltUnknown;
      endcase
   endfunction

   // Expected read data is the start word or the shadow copy
   function automatic ks10Pkg::busWordT expectRead(logic [17:0] ad);
      if (ad == `CON_VECTOR_ADDR)
         return `CON_START_WORD;
      return shadow[ad - `CON_STAT_BASE];
   endfunction

   task automatic checkValue(string name, logic [35:0] expected, logic [35:0] actual);
      if (expected !== actual)
      begin
         $display("FAIL %s expected %o actual %o", name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic abortRun(string why);
      $display("ERROR %s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run aborted");
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Reads queue their answer and writes update the shadow at issue time since the DUT keeps order
   task automatic modelCycle(ks10Pkg::busWordT a, ks10Pkg::busWordT d);
      logic [17:0] ad;
      int          idx;
      ad  = a[18:35];
      idx = -1;
      if (a[`KS_PHYS_BIT] && a[`KS_IO_BIT] && a[`KS_READ_BIT])
      begin
         if (ad == `CON_VECTOR_ADDR ||
             (ad >= `CON_STAT_BASE && ad < `CON_STAT_BASE + `HSB_COUNT))
         begin
            ackQ.push_back(expectRead(ad));
         end
      end
      else if (a[`KS_PHYS_BIT] && !a[`KS_IO_BIT] && a[`KS_WRITE_BIT])
      begin
         if (ad <= 18'o000001)
            idx = ad;
         else if (ad >= `HSB_REG_BASE && ad < `HSB_REG_BASE + `HSB_COUNT - 2)
            idx = ad - `HSB_REG_BASE + 2;
         if (idx >= 0)
            shadow[idx] = d;
         if (idx == 0)
            causeQ.push_back(causeOf(d[24:35]));
      end
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Holds the request until a cycle with clken high has carried it
   task automatic sendCycle(ks10Pkg::busWordT a, ks10Pkg::busWordT d);
      logic en;
      modelCycle(a, d);
      en = 1'b0;
      while (!en)
      begin
         en = randEnable();
         @(posedge clk);
         clken    <= en;
         busREQI  <= 1'b1;
         busADDRI <= a;
         busDATAI <= d;
      end
   endtask

   task automatic idleCycle();
      @(posedge clk);
      clken   <= randEnable();
      busREQI <= 1'b0;
   endtask

   task automatic readAllStatus();
      for (int i = 0; i < `HSB_COUNT; i++)
         sendCycle(makeAddr(1, 0, 1, 1, 18'(`CON_STAT_BASE + i)), '0);
   endtask

   //////////////////////////////
   // Response compare
   //////////////////////////////

   // Outputs are read before this edge updates them and only on clken edges
   always @(posedge clk)
   begin
      ks10Pkg::busWordT   expWord;
      ks10Pkg::haltCauseT expCause;
      if (rstN && clken)
      begin
         if (busACKO)
         begin
            if (ackQ.size() == 0)
               abortRun($sformatf("acknowledge without an outstanding read in %s", testName));
            expWord = ackQ.pop_front();
            checkValue({testName, " data"}, expWord, busDATAO);
         end
         else
            checkValue({testName, " idle data"}, '0, busDATAO);
         if (haltValid)
         begin
            if (causeQ.size() == 0)
               abortRun($sformatf("haltValid without a cause write in %s", testName));
            expCause = causeQ.pop_front();
            checkValue({testName, " cause"}, expCause, haltCause);
         end
      end
   end

   initial
   begin
      #(watchdogTime);
      abortRun("watchdog expired, the DUT stopped answering");
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      int          j;
      logic [2:0]  kind;
      ks10Pkg::busWordT d;
      rstN     = 1'b0;
      clken    = 1'b0;
      busREQI  = 1'b0;
      busADDRI = '0;
      busDATAI = '0;
      for (int i = 0; i < `HSB_COUNT; i++)
         shadow[i] = '0;
      repeat (4) @(posedge clk);
      rstN <= 1'b1;
      @(posedge clk);
      checkValue("reset cause", ks10Pkg::haltStartup, haltCause);
      checkValue("reset ack", '0, busACKO);

      testName = "vector read";
      sendCycle(makeAddr(1, 0, 1, 0, 18'o0), '0);
      sendCycle(makeAddr(1, 0, 1, 1, `CON_VECTOR_ADDR), '0);

      // PC and saved registers, then read everything back
      testName = "status writes";
      sendCycle(makeAddr(0, 1, 1, 0, 18'o000001), randWord());
      for (int i = 0; i < `HSB_COUNT - 2; i++)
         sendCycle(makeAddr(0, 1, 1, 0, 18'(`HSB_REG_BASE + i)), randWord());
      readAllStatus();

      testName = "halt causes";
      foreach (causeCodes[i])
      begin
         d = randWord();
         d[24:35] = causeCodes[i];
         sendCycle(makeAddr(0, 1, 1, 0, 18'o000000), d);
         sendCycle(makeAddr(1, 0, 1, 1, `CON_STAT_BASE), '0);
      end

      // None of these may answer or touch a register
      testName = "ignored cycles";
      sendCycle(makeAddr(0, 1, 0, 0, `HSB_REG_BASE), randWord());
      sendCycle(makeAddr(0, 1, 1, 1, 18'o376001), randWord());
      sendCycle(makeAddr(1, 0, 1, 1, 18'o200200), '0);
      sendCycle(makeAddr(1, 0, 1, 0, 18'o000001), '0);
      sendCycle(makeAddr(1, 0, 0, 1, `CON_VECTOR_ADDR), '0);
      readAllStatus();

      testName = "random traffic";
      for (int n = 0; n < numRandom; n++)
      begin
         kind = nextRand() >> 29;
         j = nextRand() % 20;
         d = randWord();
         if (kind == 0)
            sendCycle(makeAddr(1, 0, 1, 1, `CON_VECTOR_ADDR), '0);
         else if (kind <= 2)
            sendCycle(makeAddr(1, 0, 1, 1, 18'(`CON_STAT_BASE + j)), '0);
         else if (kind <= 4)
            sendCycle(makeAddr(0, 1, 1, 0, (j < 2) ? 18'(j) : 18'(`HSB_REG_BASE + j - 2)), d);
         else if (kind == 5)
            sendCycle(makeAddr(1, 0, 1, 1, 18'(`CON_STAT_BASE + 20 + j)), '0);
         else if (kind == 6)
            sendCycle(makeAddr(0, 1, j[0], !j[0], 18'(`HSB_REG_BASE + j)), d);
         else
            sendCycle(makeAddr(1, 0, 1, 0, 18'(`HSB_REG_BASE + j)), '0);
         if (nextRand() > 32'hc000_0000)
            idleCycle();
      end

      // Drain the pipeline, then look for stray acknowledges
      while (ackQ.size() != 0 || causeQ.size() != 0)
         idleCycle();
      repeat (8) idleCycle();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
ks10Pkg.sv
busDecode.sv
statusCapture.sv
conResponse.sv
conTop.sv
tbCon.sv

//--- Bender.yml
package:
  name: ks10Console

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ks10Pkg.sv
      - busDecode.sv
      - statusCapture.sv
      - conResponse.sv
      - conTop.sv
  - target: simulation
    files:
      - tbCon.sv
